// ==== files.f ====
+incdir+include
verilog/fx2_pkg.sv
verilog/fx2_bidir.sv
verilog/cmd_decoder.sv
verilog/photon_counter.sv
verilog/tx_arbiter.sv
verilog/led_driver.sv
verilog/fx2_counter.sv
test/fx2_model.sv
test/fx2_counter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fx2_counter_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --timing --assert
SIM_FLAGS ?= --timing --assert
PASS_TEXT ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/fx2_testdata.txt ====
# One directive per line. C byte(hex) queues a command; P mask(hex) n drives n pulses;
# W n waits n cycles; E word(hex) expects a reply word; T name closes a test.
W 8
T idle
C 15
W 16
T laser
C 1a
C 31
W 24
T run_on
C 30
W 150
T run_off
C 23
C 40
E 8100
W 60
T gate_reply
C 31
W 16
P 1 5
P 6 3
W 300
P f 4
W 40
C 30
W 150
T counts
C 20
C 40
E 8040
C 31
W 16
P 8 20
P 3 7
W 8
C 30
W 150
T backpressure
P 2 1
W 20
T led

// ==== test/fx2_counter_tb.sv ====
`include "fx2_consts.svh"

module fx2_counter_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam string DATA_FILE = "test/fx2_testdata.txt";
	localparam int MAX_DIRS = 64;
	localparam int REPLY_WAIT = 400;
	localparam int LED_CYCLES = 4000;

	logic fx2_clk;
	logic arst_n;
	logic [3:0] detectors;
	logic cmd_push;
	logic [7:0] cmd_byte;
	wire [7:0] fx2_fd;
	logic [2:0] fx2_flags;
	logic fx2_slwr;
	logic fx2_slrd;
	logic fx2_sloe;
	logic fx2_wu2;
	logic fx2_pktend;
	logic [1:0] fx2_fifoadr;
	logic [3:0] laser_en;
	logic [1:0] led;
	logic running;
	logic [3:0] debug;
	logic word_stb;
	logic [15:0] word_dat;
	logic pkt_stb;
	logic half_word;
	logic proto_err;

	byte dir_op [MAX_DIRS];
	int dir_a [MAX_DIRS];
	int dir_b [MAX_DIRS];
	string dir_name [MAX_DIRS];
	int n_dirs;
	int wd_cycles;

	logic [15:0] replies [$];
	logic [15:0] counts [$];
	int words_total;
	int pkt_since_word;
	int pulses_run [4];
	logic [3:0] exp_laser;
	logic exp_run;
	int runs;
	bit any_pulse;
	time last_pulse;
	bit any_cmd;
	time last_cmd;
	int test_errs;
	int tests;
	int failed_tests;
	int total_errs;

	fx2_counter u_fx2_counter (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.fx2_flags(fx2_flags),
		.fx2_FD(fx2_fd),
		.fx2_SLWR(fx2_slwr),
		.fx2_SLRD(fx2_slrd),
		.fx2_SLOE(fx2_sloe),
		.fx2_WU2(fx2_wu2),
		.fx2_PKTEND(fx2_pktend),
		.fx2_FIFOADR(fx2_fifoadr),
		.detectors(detectors),
		.laser_en(laser_en),
		.led(led),
		.running(running),
		.debug(debug)
	);

	fx2_model u_model (
		.clk(fx2_clk),
		.arst_n(arst_n),
		.fd(fx2_fd),
		.slwr(fx2_slwr),
		.slrd(fx2_slrd),
		.sloe(fx2_sloe),
		.pktend(fx2_pktend),
		.fifoadr(fx2_fifoadr),
		.flags(fx2_flags),
		.cmd_push(cmd_push),
		.cmd_byte(cmd_byte),
		.word_stb(word_stb),
		.word_dat(word_dat),
		.pkt_stb(pkt_stb),
		.half_word(half_word),
		.proto_err(proto_err)
	);

	initial begin
		fx2_clk = 1'b0;
		forever #4 fx2_clk = ~fx2_clk;
	end

	// Collected on the falling edge, away from the sampling edge.
	always @(negedge fx2_clk) begin
		if (word_stb) begin
			if (word_dat[15])
				replies.push_back(word_dat);
			else
				counts.push_back(word_dat);
			words_total++;
			pkt_since_word = 0;
		end
		if (pkt_stb)
			pkt_since_word++;
	end

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
			test_errs++;
		end
	endtask

	task automatic load_testdata();
		int fd;
		int a;
		int b;
		string line;
		string op;
		string name;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			n_dirs = -1;
		end else begin
			n_dirs = 0;
			wd_cycles = 16;
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				void'($sscanf(line, "%s", op));
				a = 0;
				b = 0;
				name = "";
				case (op.getc(0))
					"C", "E": void'($sscanf(line, "%s %h", op, a));
					"P": void'($sscanf(line, "%s %h %d", op, a, b));
					"W": void'($sscanf(line, "%s %d", op, a));
					default: void'($sscanf(line, "%s %s", op, name));
				endcase
				if (n_dirs < MAX_DIRS) begin
					dir_op[n_dirs] = op.getc(0);
					dir_a[n_dirs] = a;
					dir_b[n_dirs] = b;
					dir_name[n_dirs] = name;
					n_dirs++;
					wd_cycles += 64 + ((op == "W") ? a : 0);
				end
			end
			$fclose(fd);
		end
	endtask

	// All sets must be complete once the counter is stopped.
	task automatic check_stream();
		int sum [4];
		int ch;
		for (int c = 0; c < 4; c++)
			sum[c] = 0;
		check(counts.size() % 4 == 0, $sformatf("%0d count words is not whole sets", counts.size()));
		check(counts.size() / 4 >= runs, $sformatf("only %0d sets for %0d runs", counts.size() / 4, runs));
		check(replies.size() == 0, "a reply word arrived that no request asked for");
		for (int i = 0; i < counts.size(); i++) begin
			ch = int'(counts[i][14:13]);
			check(ch == i % 4, $sformatf("word %0d carries channel %0d out of order", i, ch));
			sum[ch] += int'(counts[i][12:0]);
		end
		for (int c = 0; c < 4; c++)
			check(sum[c] == pulses_run[c],
				$sformatf("channel %0d counted %0d, expected %0d", c, sum[c], pulses_run[c]));
	endtask

	task automatic close_test(input string name);
		@(negedge fx2_clk);
		check(laser_en == exp_laser, $sformatf("laser_en %h, expected %h", laser_en, exp_laser));
		check(running == exp_run, $sformatf("running %b, expected %b", running, exp_run));
		check(!proto_err, "FX2 model reported a bus protocol violation");
		if (!exp_run) begin
			check_stream();
			check(!half_word, "a low byte arrived without its high byte");
			check(debug == 4'(fx2_pkg::idle),
				$sformatf("engine state %0d, expected idle", debug));
			if (words_total > 0)
				check(pkt_since_word == 1,
					$sformatf("PKTEND pulsed %0d times after the last word", pkt_since_word));
		end
		if (any_pulse && ($time - last_pulse) < LED_CYCLES * 8)
			check(led[1], "photon LED is off after a recent detector pulse");
		if (any_cmd && ($time - last_cmd) < LED_CYCLES * 8)
			check(led[0], "command LED is off after a recent command");
		tests++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%-14s passed", name);
		end else begin
			failed_tests++;
			$display("%-14s failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic run_directive(input int i);
		bit found;
		logic [15:0] got;
		case (dir_op[i])
			"C": begin
				@(posedge fx2_clk);
				cmd_push <= 1'b1;
				cmd_byte <= 8'(dir_a[i]);
				@(posedge fx2_clk);
				cmd_push <= 1'b0;
				any_cmd = 1'b1;
				last_cmd = $time;
				// Expected state follows the opcode rules.
				if (dir_a[i][7:4] == `CMD_LASER)
					exp_laser = dir_a[i][3:0];
				if (dir_a[i][7:4] == `CMD_RUN) begin
					if (!exp_run && dir_a[i][0])
						runs++;
					exp_run = dir_a[i][0];
				end
			end
			"P": begin
				for (int c = 0; c < 4; c++)
					if (exp_run && dir_a[i][c])
						pulses_run[c] += dir_b[i];
				repeat (dir_b[i]) begin
					@(posedge fx2_clk);
					detectors <= 4'(dir_a[i]);
					@(posedge fx2_clk);
					detectors <= 4'b0;
				end
				any_pulse = 1'b1;
				last_pulse = $time;
			end
			"W": repeat (dir_a[i]) @(posedge fx2_clk);
			"E": begin
				found = 1'b0;
				for (int t = 0; t < REPLY_WAIT && !found; t++) begin
					@(posedge fx2_clk);
					found = (replies.size() > 0);
				end
				if (found) begin
					got = replies.pop_front();
					check(got == 16'(dir_a[i]),
						$sformatf("reply word %h, expected %h", got, 16'(dir_a[i])));
				end else begin
					$display("No reply word arrived within %0d cycles of the request", REPLY_WAIT);
					test_errs++;
				end
			end
			"T": close_test(dir_name[i]);
			default: begin
				$display("Unknown directive in the test data at entry %0d", i);
				test_errs++;
			end
		endcase
	endtask

	task automatic run_tests();
		repeat (3) @(posedge fx2_clk);
		arst_n <= 1'b1;
		@(negedge fx2_clk);
		check(fx2_slwr && fx2_slrd && fx2_sloe, "FX2 strobes are not idle after reset");
		check(fx2_pktend && fx2_wu2, "PKTEND or WU2 is low after reset");
		check(laser_en == 4'b0 && !running && led == 2'b0, "outputs are not cleared after reset");
		check(debug == 4'(fx2_pkg::idle), "FX2 engine is not idle after reset");
		close_test("reset");
		for (int i = 0; i < n_dirs; i++)
			run_directive(i);
	endtask

	initial begin
		arst_n = 1'b0;
		detectors = 4'b0;
		cmd_push = 1'b0;
		cmd_byte = 8'h00;
		exp_laser = 4'b0;
		exp_run = 1'b0;
		load_testdata();
		if (n_dirs < 0) begin
			$display("Could not open %s", DATA_FILE);
			$display("TEST FAILED");
			$finish;
		end else begin
			run_tests();
			$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, total_errs);
			if (failed_tests == 0 && total_errs == 0 && test_errs == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// Budget grows with the waits and the number of directives.
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge fx2_clk);
		$display("Watchdog expired after %0d cycles and the run did not finish", wd_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== test/fx2_model.sv ====
`include "fx2_consts.svh"

module fx2_model (
	input logic clk,
	input logic arst_n,
	inout wire [7:0] fd,
	input logic slwr,
	input logic slrd,
	input logic sloe,
	input logic pktend,
	input logic [1:0] fifoadr,
	output logic [2:0] flags,
	input logic cmd_push,
	input logic [7:0] cmd_byte,
	output logic word_stb,
	output logic [15:0] word_dat,
	output logic pkt_stb,
	output logic half_word,
	output logic proto_err
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'h2121_c23f;

	logic [7:0] out_mem [16];
	logic [3:0] wr_idx;
	logic [3:0] rd_idx;
	logic [31:0] rnd;
	logic not_full;
	logic [7:0] low_byte;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// OUT not empty on bit 0, IN not full on bit 1.
	assign flags = {1'b0, not_full, rd_idx != wr_idx};

	// The chip drives FD whenever SLOE is low.
	assign fd = sloe ? 'z : out_mem[rd_idx];

	always @(posedge clk) begin
		if (cmd_push)
			out_mem[wr_idx] <= cmd_byte;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
			rnd <= SEED;
			not_full <= 1'b1;
			low_byte <= '0;
			half_word <= 1'b0;
			word_stb <= 1'b0;
			word_dat <= '0;
			pkt_stb <= 1'b0;
			proto_err <= 1'b0;
		end else begin
			rnd <= xorshift32(rnd);
			// About one cycle in four the IN FIFO reports full.
			not_full <= (rnd[1:0] != 2'b00);
			word_stb <= 1'b0;
			pkt_stb <= !pktend;
			if (cmd_push)
				wr_idx <= wr_idx + 1'b1;
			if (!slrd) begin
				rd_idx <= rd_idx + 1'b1;
				if (fifoadr != `FX2_ADDR_OUT || rd_idx == wr_idx) begin
					$display("FX2 model at %0t: read strobe with no byte or wrong address", $time);
					proto_err <= 1'b1;
				end
			end
			if (!slwr) begin
				if (fifoadr != `FX2_ADDR_IN || !not_full) begin
					$display("FX2 model at %0t: write strobe the IN FIFO cannot take", $time);
					proto_err <= 1'b1;
				end
				// Low byte arrives first.
				if (half_word) begin
					word_dat <= {fd, low_byte};
					word_stb <= 1'b1;
				end else begin
					low_byte <= fd;
				end
				half_word <= !half_word;
			end
		end
	end

endmodule

// ==== verilog/fx2_counter.sv ====
module fx2_counter (
	input logic fx2_clk,
	input logic arst_n,
	input logic [2:0] fx2_flags,
	inout wire fx2_pkg::fx2_byte_t fx2_FD,
	output logic fx2_SLWR,
	output logic fx2_SLRD,
	output logic fx2_SLOE,
	output logic fx2_WU2,
	output logic fx2_PKTEND,
	output logic [1:0] fx2_FIFOADR,
	input logic [3:0] detectors,
	output logic [3:0] laser_en,
	output logic [1:0] led,
	output logic running,
	output logic [3:0] debug
);
	import fx2_pkg::*;

	wb_req_t cnt_req;
	wb_req_t dec_req;
	wb_req_t bus_req;
	wb_rsp_t cnt_rsp;
	wb_rsp_t dec_rsp;
	wb_rsp_t bus_rsp;
	fx2_byte_t cmd;
	logic cmd_wr;
	gate_len_t gate_len;
	logic photon_seen;

	// Remote wake-up is not used.
	assign fx2_WU2 = 1'b1;

	fx2_bidir u_bidir (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.flags(fx2_flags[1:0]),
		.fd(fx2_FD),
		.slwr(fx2_SLWR),
		.slrd(fx2_SLRD),
		.sloe(fx2_SLOE),
		.pktend(fx2_PKTEND),
		.fifoadr(fx2_FIFOADR),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.cmd_wr(cmd_wr),
		.cmd(cmd),
		.state(debug)
	);

	cmd_decoder u_decoder (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.cmd_wr(cmd_wr),
		.cmd(cmd),
		.laser_en(laser_en),
		.running(running),
		.gate_len(gate_len),
		.wb_req(dec_req),
		.wb_rsp(dec_rsp)
	);

	photon_counter u_counter (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.detectors(detectors),
		.running(running),
		.gate_len(gate_len),
		.wb_req(cnt_req),
		.wb_rsp(cnt_rsp),
		.photon_seen(photon_seen)
	);

	// Counter on port 0, command replies on port 1.
	tx_arbiter u_arbiter (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.req0(cnt_req),
		.req1(dec_req),
		.rsp0(cnt_rsp),
		.rsp1(dec_rsp),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	led_driver u_led_cmd (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.pulse(cmd_wr),
		.led(led[0])
	);

	led_driver u_led_photon (
		.fx2_clk(fx2_clk),
		.arst_n(arst_n),
		.pulse(photon_seen),
		.led(led[1])
	);

endmodule

// ==== verilog/led_driver.sv ====
`include "fx2_consts.svh"

module led_driver (
	input logic fx2_clk,
	input logic arst_n,
	input logic pulse,
	output logic led
);

	logic [`LED_HOLD_BITS-1:0] hold;

	// Each pulse restarts the full hold time.
	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n)
			hold <= '0;
		else if (pulse)
			hold <= '1;
		else if (hold != '0)
			hold <= hold - 1'b1;
	end

	assign led = |hold;

endmodule

// ==== verilog/tx_arbiter.sv ====
module tx_arbiter (
	input logic fx2_clk,
	input logic arst_n,
	input fx2_pkg::wb_req_t req0,
	input fx2_pkg::wb_req_t req1,
	output fx2_pkg::wb_rsp_t rsp0,
	output fx2_pkg::wb_rsp_t rsp1,
	output fx2_pkg::wb_req_t bus_req,
	input fx2_pkg::wb_rsp_t bus_rsp
);
	import fx2_pkg::*;

	logic owner;
	logic locked;
	logic pick;
	logic grant;
	logic owner_cyc;

	// On a tie the master that did not own the bus last time wins.
	assign pick = (req0.cyc && req1.cyc) ? !owner : req1.cyc;
	assign grant = locked ? owner : pick;
	assign owner_cyc = owner ? req1.cyc : req0.cyc;

	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			owner <= 1'b1;
			locked <= 1'b0;
		end else if (locked) begin
			if (!owner_cyc)
				locked <= 1'b0;
		end else if (req0.cyc || req1.cyc) begin
			owner <= pick;
			locked <= 1'b1;
		end
	end

	assign bus_req = grant ? req1 : req0;
	assign rsp0 = '{ack: bus_rsp.ack && !grant};
	assign rsp1 = '{ack: bus_rsp.ack && grant};

	// An ack must land on a master with a live strobe.
	a_ack0_live: assert property (@(posedge fx2_clk) disable iff (!arst_n)
		rsp0.ack |-> (req0.cyc && req0.stb));
	a_ack1_live: assert property (@(posedge fx2_clk) disable iff (!arst_n)
		rsp1.ack |-> (req1.cyc && req1.stb));

endmodule

// ==== verilog/photon_counter.sv ====
module photon_counter (
	input logic fx2_clk,
	input logic arst_n,
	input logic [3:0] detectors,
	input logic running,
	input fx2_pkg::gate_len_t gate_len,
	output fx2_pkg::wb_req_t wb_req,
	input fx2_pkg::wb_rsp_t wb_rsp,
	output logic photon_seen
);
	import fx2_pkg::*;

	typedef enum logic [1:0] {pc_idle, pc_gate, pc_emit} pc_state_t;

	localparam logic [12:0] CNT_MAX = '1;

	logic [3:0] det_meta;
	logic [3:0] det_sync;
	logic [3:0] det_prev;
	logic [3:0] rise;
	logic [12:0] cnt [4];
	logic [12:0] snap [4];
	gate_len_t gate_cnt;
	pc_state_t state_q;
	logic [1:0] ch;
	logic last_set;
	logic stb_gap;
	logic take;
	logic emit;

	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			det_meta <= 4'b0;
			det_sync <= 4'b0;
			det_prev <= 4'b0;
		end else begin
			det_meta <= detectors;
			det_sync <= det_meta;
			det_prev <= det_sync;
		end
	end

	assign rise = det_sync & ~det_prev;
	assign photon_seen = |rise;

	// Snapshot at window end, at stop, or for a stop that came during emission.
	assign take = (state_q == pc_gate && (!running || gate_cnt >= gate_len - 1'b1)) ||
		(state_q == pc_emit && wb_rsp.ack && ch == 2'd3 && !last_set && !running);

	// An edge in the snapshot cycle goes into the new window.
	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (take)
					cnt[i] <= {12'b0, rise[i] & running};
				else if (running && rise[i] && cnt[i] != CNT_MAX)
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	always_ff @(posedge fx2_clk) begin
		if (take) begin
			for (int i = 0; i < 4; i++)
				snap[i] <= cnt[i];
		end
	end

	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= pc_idle;
			gate_cnt <= '0;
			ch <= 2'd0;
			last_set <= 1'b0;
			stb_gap <= 1'b0;
		end else begin
			stb_gap <= wb_rsp.ack;
			case (state_q)
				pc_idle: begin
					if (running) begin
						state_q <= pc_gate;
						gate_cnt <= '0;
					end
				end
				pc_gate: begin
					if (take) begin
						state_q <= pc_emit;
						ch <= 2'd0;
						last_set <= !running;
					end else begin
						gate_cnt <= gate_cnt + 1'b1;
					end
				end
				default: begin
					if (wb_rsp.ack) begin
						// ch wraps to 0 after the fourth word.
						ch <= ch + 1'b1;
						if (ch == 2'd3) begin
							if (take) begin
								last_set <= 1'b1;
							end else if (running) begin
								state_q <= pc_gate;
								gate_cnt <= '0;
							end else begin
								state_q <= pc_idle;
							end
						end
					end
				end
			endcase
		end
	end

	// Cyc stays up across the four words so the arbiter keeps the grant.
	assign emit = (state_q == pc_emit);
	assign wb_req = '{cyc: emit, stb: emit && !stb_gap, we: emit, dat: {1'b0, ch, snap[ch]}};

	for (genvar i = 0; i < 4; i++) begin : g_sat
		a_no_wrap: assert property (@(posedge fx2_clk) disable iff (!arst_n)
			(cnt[i] == CNT_MAX && !take) |=> (cnt[i] == CNT_MAX));
	end

endmodule

// ==== verilog/cmd_decoder.sv ====
`include "fx2_consts.svh"

module cmd_decoder (
	input logic fx2_clk,
	input logic arst_n,
	input logic cmd_wr,
	input fx2_pkg::fx2_byte_t cmd,
	output logic [3:0] laser_en,
	output logic running,
	output fx2_pkg::gate_len_t gate_len,
	output fx2_pkg::wb_req_t wb_req,
	input fx2_pkg::wb_rsp_t wb_rsp
);
	import fx2_pkg::*;

	logic [3:0] opcode;
	logic [3:0] arg;
	logic req_len;
	logic reply_cyc;
	tx_word_t reply_dat;

	assign opcode = cmd[7:4];
	assign arg = cmd[3:0];
	assign req_len = cmd_wr && (opcode == `CMD_REQ_LEN);

	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			laser_en <= 4'b0;
			running <= 1'b0;
			gate_len <= gate_len_t'(`GATE_STEP);
		end else if (cmd_wr) begin
			case (opcode)
				`CMD_LASER: laser_en <= arg;
				`CMD_GATE: gate_len <= gate_len_t'((int'(arg) + 1) * `GATE_STEP);
				`CMD_RUN: running <= arg[0];
				default: ;
			endcase
		end
	end

	// Only one reply in flight; further requests fold into it.
	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n)
			reply_cyc <= 1'b0;
		else if (req_len && !reply_cyc)
			reply_cyc <= 1'b1;
		else if (wb_rsp.ack)
			reply_cyc <= 1'b0;
	end

	always_ff @(posedge fx2_clk) begin
		if (req_len && !reply_cyc)
			reply_dat <= {1'b1, gate_len};
	end

	assign wb_req = '{cyc: reply_cyc, stb: reply_cyc, we: reply_cyc, dat: reply_dat};

endmodule

// ==== verilog/fx2_bidir.sv ====
`include "fx2_consts.svh"

module fx2_bidir (
	input logic fx2_clk,
	input logic arst_n,
	input logic [1:0] flags,
	inout wire fx2_pkg::fx2_byte_t fd,
	output logic slwr,
	output logic slrd,
	output logic sloe,
	output logic pktend,
	output logic [1:0] fifoadr,
	input fx2_pkg::wb_req_t bus_req,
	output fx2_pkg::wb_rsp_t bus_rsp,
	output logic cmd_wr,
	output fx2_pkg::fx2_byte_t cmd,
	output fx2_pkg::fx2_state_t state
);
	import fx2_pkg::*;

	localparam int IDLE_W = $clog2(`FLUSH_IDLE + 1);

	fx2_state_t state_q;
	fx2_state_t state_d;
	logic [IDLE_W-1:0] idle_cnt;
	logic flush_pend;
	logic out_ready;
	logic in_ready;
	logic drive_fd;
	logic wr_fire;
	fx2_byte_t wr_byte;

	// flags[0] is OUT not empty, flags[1] is IN not full.
	assign out_ready = flags[0];
	assign in_ready = flags[1];

	// Reads win over writes, writes win over a pending flush.
	always_comb begin
		state_d = state_q;
		case (state_q)
			idle: begin
				if (out_ready)
					state_d = rd_setup;
				else if (bus_req.cyc && bus_req.stb)
					state_d = wr_low;
				else if (flush_pend && idle_cnt == IDLE_W'(`FLUSH_IDLE))
					state_d = flush;
			end
			rd_setup: state_d = rd_strobe;
			rd_strobe: state_d = idle;
			wr_low: if (in_ready) state_d = wr_high;
			wr_high: if (in_ready) state_d = idle;
			default: state_d = idle;
		endcase
	end

	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= idle;
			cmd_wr <= 1'b0;
		end else begin
			state_q <= state_d;
			cmd_wr <= (state_q == rd_strobe);
		end
	end

	// The byte is on FD while SLOE is low; latch it in the SLRD cycle.
	always_ff @(posedge fx2_clk) begin
		if (state_q == rd_strobe)
			cmd <= fd;
	end

	// Idle timer for committing a short packet.
	always_ff @(posedge fx2_clk or negedge arst_n) begin
		if (!arst_n) begin
			idle_cnt <= '0;
			flush_pend <= 1'b0;
		end else if (state_q == wr_high && in_ready) begin
			idle_cnt <= '0;
			flush_pend <= 1'b1;
		end else if (state_q == flush) begin
			idle_cnt <= '0;
			flush_pend <= 1'b0;
		end else if (drive_fd) begin
			idle_cnt <= '0;
		end else if (flush_pend && idle_cnt != IDLE_W'(`FLUSH_IDLE)) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	assign drive_fd = (state_q == wr_low) || (state_q == wr_high);
	assign wr_fire = drive_fd && in_ready;
	assign wr_byte = (state_q == wr_high) ? bus_req.dat[15:8] : bus_req.dat[7:0];
	assign fd = drive_fd ? wr_byte : 'z;

	assign slwr = !wr_fire;
	assign slrd = (state_q != rd_strobe);
	assign sloe = !(state_q inside {rd_setup, rd_strobe});
	assign pktend = (state_q != flush);
	assign fifoadr = sloe ? `FX2_ADDR_IN : `FX2_ADDR_OUT;

	// Ack coincides with the high byte leaving.
	assign bus_rsp = '{ack: (state_q == wr_high) && in_ready};
	assign state = state_q;

	// A byte goes out only for a request that is still live.
	a_wr_live: assert property (@(posedge fx2_clk) disable iff (!arst_n)
		!slwr |-> (slrd && bus_req.cyc && bus_req.stb));

	// Both bytes on FD come from the same word.
	a_word_stable: assert property (@(posedge fx2_clk) disable iff (!arst_n)
		(state_q == wr_high) |-> (bus_req.dat == $past(bus_req.dat)));

endmodule

// ==== verilog/fx2_pkg.sv ====
package fx2_pkg;

	// One byte on the FX2 data bus, also used for command bytes.
	typedef logic [7:0] fx2_byte_t;

	// Word sent to the host as two bytes, low byte first.
	typedef logic [15:0] tx_word_t;

	// Gate window length in cycles.
	typedef logic [14:0] gate_len_t;

	// Wishbone classic request, driven by a master.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		tx_word_t dat;
	} wb_req_t;

	// Wishbone response, driven by the slave.
	typedef struct packed {
		logic ack;
	} wb_rsp_t;

	// Slave-FIFO engine states; the code goes out on the debug pins.
	typedef enum logic [3:0] {
		idle = 4'd0,
		rd_setup = 4'd1,
		rd_strobe = 4'd2,
		wr_low = 4'd3,
		wr_high = 4'd4,
		flush = 4'd5
	} fx2_state_t;

endpackage

// ==== include/fx2_consts.svh ====
`ifndef FX2_CONSTS_SVH
`define FX2_CONSTS_SVH

// FIFOADR values for the two endpoints in use.
`define FX2_ADDR_OUT 2'b00
`define FX2_ADDR_IN 2'b10

// Command opcodes, carried in the high nibble of a command byte.
`define CMD_LASER 4'h1
`define CMD_GATE 4'h2
`define CMD_RUN 4'h3
`define CMD_REQ_LEN 4'h4

// Gate length granularity in cycles.
`define GATE_STEP 64

// Idle cycles after the last written byte before PKTEND.
`define FLUSH_IDLE 32

// Width of the LED hold counter.
`define LED_HOLD_BITS 12

`endif
